// File: logic/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and address width
`define CORE_XLEN 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Architectural registers
`define CORE_NREGS 32

`endif

// File: logic/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_XLEN-1:0] addr_t;
    typedef logic [31:0]           inst_t;
    typedef logic [4:0]            reg_addr_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // ALT funct7 selects SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: logic/core_top.sv
interface fetch_if;
    import core_pkg::*;

    logic  valid;
    logic  ready;
    addr_t pc;
    inst_t inst;

    modport source (output valid, output pc, output inst, input ready);
    modport sink (input valid, input pc, input inst, output ready);
endinterface

interface retire_if;
    import core_pkg::*;

    logic      valid;
    addr_t     pc;
    inst_t     inst;
    reg_addr_t rd;
    logic      we;
    word_t     wdata;

    modport source (output valid, output pc, output inst, output rd, output we, output wdata);
    modport sink (input valid, input pc, input inst, input rd, input we, input wdata);
endinterface

module core_top (
    input  logic                clk,
    input  logic                rst,
    // Instruction bus
    output logic                ireq_valid,
    output core_pkg::addr_t     ireq_addr,
    input  logic                iresp_valid,
    input  core_pkg::inst_t     iresp_data,
    // Commit trace
    output logic                commit_valid,
    output core_pkg::addr_t     commit_pc,
    output core_pkg::inst_t     commit_inst,
    output logic                commit_we,
    output core_pkg::reg_addr_t commit_rd,
    output core_pkg::word_t     commit_wdata
);
    import core_pkg::*;

    logic      redirect;
    addr_t     redirect_pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    fetch_if  fe_bus ();
    retire_if rt_bus ();

    fetch_stage fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_data  (iresp_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fe          (fe_bus.source)
    );

    // Forward path comes straight from commit's held write
    execute_stage execute_inst (
        .clk         (clk),
        .rst         (rst),
        .fe          (fe_bus.sink),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .fwd_we      (wr_en),
        .fwd_rd      (wr_addr),
        .fwd_data    (wr_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rt          (rt_bus.source)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    commit_stage commit_inst_u (
        .clk          (clk),
        .rst          (rst),
        .rt           (rt_bus.sink),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

endmodule

// File: logic/fetch_stage.sv
`include "core_defs.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            rst,
    output logic            ireq_valid,
    output core_pkg::addr_t ireq_addr,
    input  logic            iresp_valid,
    input  core_pkg::inst_t iresp_data,
    input  logic            redirect,
    input  core_pkg::addr_t redirect_pc,
    fetch_if.source         fe
);
    import core_pkg::*;

    logic  req_q;
    logic  discard_q;
    addr_t req_addr_q;
    addr_t next_pc_q;
    logic  out_valid_q;
    addr_t out_pc_q;
    inst_t out_inst_q;

    logic  resp;
    logic  keep_resp;
    logic  slot_free;
    logic  issue;
    addr_t issue_pc;

    assign resp      = req_q & iresp_valid;
    assign keep_resp = resp & ~discard_q & ~redirect;
    // Output register empty, being taken or being flushed
    assign slot_free = ~out_valid_q | fe.ready | redirect;
    assign issue     = (~req_q | resp) & slot_free;
    assign issue_pc  = redirect ? redirect_pc : next_pc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q       <= 1'b0;
            discard_q   <= 1'b0;
            req_addr_q  <= `CORE_RESET_PC;
            next_pc_q   <= `CORE_RESET_PC;
            out_valid_q <= 1'b0;
        end else begin
            if (issue) begin
                req_q      <= 1'b1;
                req_addr_q <= issue_pc;
                next_pc_q  <= issue_pc + 32'd4;
            end else begin
                if (resp) begin
                    req_q <= 1'b0;
                end
                if (redirect) begin
                    next_pc_q <= redirect_pc;
                end
            end

            // Response still in flight belongs to the wrong path
            if (redirect && req_q && !iresp_valid) begin
                discard_q <= 1'b1;
            end else if (resp) begin
                discard_q <= 1'b0;
            end

            if (redirect) begin
                out_valid_q <= 1'b0;
            end else if (keep_resp) begin
                out_valid_q <= 1'b1;
            end else if (fe.ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep_resp) begin
            out_pc_q   <= req_addr_q;
            out_inst_q <= iresp_data;
        end
    end

    assign ireq_valid = req_q;
    assign ireq_addr  = req_addr_q;
    assign fe.valid   = out_valid_q;
    assign fe.pc      = out_pc_q;
    assign fe.inst    = out_inst_q;

endmodule

// File: logic/execute_stage.sv
module execute_stage (
    input  logic                clk,
    input  logic                rst,
    fetch_if.sink               fe,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    input  logic                fwd_we,
    input  core_pkg::reg_addr_t fwd_rd,
    input  core_pkg::word_t     fwd_data,
    output logic                redirect,
    output core_pkg::addr_t     redirect_pc,
    retire_if.source            rt
);
    import core_pkg::*;

    logic       ex_valid_q;
    addr_t      ex_pc_q;
    inst_t      ex_inst_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    word_t      op_a;
    word_t      op_b;
    word_t      result;
    logic       we;
    logic       taken;
    addr_t      target;

    // Commit never stalls
    assign fe.ready = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= fe.valid & fe.ready & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (fe.valid && fe.ready) begin
            ex_pc_q   <= fe.pc;
            ex_inst_q <= fe.inst;
        end
    end

    assign opcode = ex_inst_q[6:0];
    assign rd     = ex_inst_q[11:7];
    assign funct3 = ex_inst_q[14:12];
    assign rs1    = ex_inst_q[19:15];
    assign rs2    = ex_inst_q[24:20];
    assign funct7 = ex_inst_q[31:25];

    assign imm_i = {{20{ex_inst_q[31]}}, ex_inst_q[31:20]};
    assign imm_u = {ex_inst_q[31:12], 12'b0};
    assign imm_b = {{19{ex_inst_q[31]}}, ex_inst_q[31], ex_inst_q[7],
                    ex_inst_q[30:25], ex_inst_q[11:8], 1'b0};
    assign imm_j = {{11{ex_inst_q[31]}}, ex_inst_q[31], ex_inst_q[19:12],
                    ex_inst_q[20], ex_inst_q[30:21], 1'b0};

    // Register file lags commit by one edge
    assign op_a = (fwd_we && fwd_rd != '0 && fwd_rd == rs1) ? fwd_data : rs1_data;
    assign op_b = (fwd_we && fwd_rd != '0 && fwd_rd == rs2) ? fwd_data : rs2_data;

    always_comb begin
        result = '0;
        we     = 1'b0;
        taken  = 1'b0;
        target = ex_pc_q + imm_b;
        case (opcode)
            OPC_OP: begin
                we = (funct7 == F7_BASE) || (funct7 == F7_ALT && funct3 == F3_ADD);
                case (funct3)
                    F3_ADD:  result = funct7[5] ? op_a - op_b : op_a + op_b;
                    F3_SLL:  result = op_a << op_b[4:0];
                    F3_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
                    F3_XOR:  result = op_a ^ op_b;
                    F3_SRL:  result = op_a >> op_b[4:0];
                    F3_OR:   result = op_a | op_b;
                    F3_AND:  result = op_a & op_b;
                    default: we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                we = 1'b1;
                case (funct3)
                    F3_ADD:  result = op_a + imm_i;
                    F3_XOR:  result = op_a ^ imm_i;
                    F3_OR:   result = op_a | imm_i;
                    F3_AND:  result = op_a & imm_i;
                    default: we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                we     = 1'b1;
                result = imm_u;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  taken = (op_a == op_b);
                    F3_BNE:  taken = (op_a != op_b);
                    default: taken = 1'b0;
                endcase
            end
            OPC_JAL: begin
                we     = 1'b1;
                result = ex_pc_q + 32'd4;
                taken  = 1'b1;
                target = ex_pc_q + imm_j;
            end
            default: we = 1'b0;
        endcase
    end

    assign redirect    = ex_valid_q & taken;
    assign redirect_pc = target;

    assign rt.valid = ex_valid_q;
    assign rt.pc    = ex_pc_q;
    assign rt.inst  = ex_inst_q;
    assign rt.rd    = rd;
    assign rt.we    = we;
    assign rt.wdata = result;

endmodule

// File: logic/reg_file.sv
`include "core_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data
);
    import core_pkg::*;

    word_t regs_q [`CORE_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs_q[wr_addr] <= wr_data;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs_q[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs_q[rs2];

endmodule

// File: logic/commit_stage.sv
module commit_stage (
    input  logic                clk,
    input  logic                rst,
    retire_if.sink              rt,
    output logic                commit_valid,
    output core_pkg::addr_t     commit_pc,
    output core_pkg::inst_t     commit_inst,
    output logic                commit_we,
    output core_pkg::reg_addr_t commit_rd,
    output core_pkg::word_t     commit_wdata,
    output logic                wr_en,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::word_t     wr_data
);
    import core_pkg::*;

    logic      valid_q;
    logic      we_q;
    addr_t     pc_q;
    inst_t     inst_q;
    reg_addr_t rd_q;
    word_t     wdata_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            valid_q <= rt.valid;
            // Writes to x0 are not architectural
            we_q    <= rt.valid & rt.we & (rt.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        pc_q    <= rt.pc;
        inst_q  <= rt.inst;
        rd_q    <= rt.rd;
        wdata_q <= rt.wdata;
    end

    assign commit_valid = valid_q;
    assign commit_pc    = pc_q;
    assign commit_inst  = inst_q;
    assign commit_we    = we_q;
    assign commit_rd    = rd_q;
    assign commit_wdata = wdata_q;

    assign wr_en   = we_q;
    assign wr_addr = rd_q;
    assign wr_data = wdata_q;

endmodule

// File: verif/core_assert.sv
module core_assert (
    input logic                clk,
    input logic                rst,
    input logic                ireq_valid,
    input core_pkg::addr_t     ireq_addr,
    input logic                iresp_valid,
    input logic                commit_valid,
    input core_pkg::addr_t     commit_pc,
    input logic                commit_we,
    input core_pkg::reg_addr_t commit_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request held until its response
    addr_held: assert property (@(posedge clk) disable iff (rst)
        ireq_valid && !iresp_valid |=> ireq_valid && $stable(ireq_addr))
        else $error("instruction request changed before its response");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !ireq_valid && !commit_valid)
        else $error("bus request or commit active right after reset");

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        commit_we |-> commit_rd != 5'd0)
        else $error("commit reports a write to register zero");

    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_pc[1:0] == 2'b00)
        else $error("committed pc is not word aligned");

endmodule

bind core_top core_assert core_assert_inst (
    .clk          (clk),
    .rst          (rst),
    .ireq_valid   (ireq_valid),
    .ireq_addr    (ireq_addr),
    .iresp_valid  (iresp_valid),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_we    (commit_we),
    .commit_rd    (commit_rd)
);

// File: verif/core_tb.sv
`include "core_defs.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int MEM_WORDS   = 64;
    localparam int NUM_COMMITS = 400;
    localparam int TIMEOUT     = 200;

    typedef struct packed {
        addr_t     pc;
        inst_t     inst;
        logic      we;
        reg_addr_t rd;
        word_t     wdata;
    } commit_rec_t;

    logic      clk;
    logic      rst;
    logic      ireq_valid;
    addr_t     ireq_addr;
    logic      iresp_valid;
    inst_t     iresp_data;
    logic      commit_valid;
    addr_t     commit_pc;
    inst_t     commit_inst;
    logic      commit_we;
    reg_addr_t commit_rd;
    word_t     commit_wdata;

    inst_t prog_mem [MEM_WORDS];
    word_t ref_regs [`CORE_NREGS];
    addr_t ref_pc;
    logic  verdict_shown;

    core_top core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .ireq_valid   (ireq_valid),
        .ireq_addr    (ireq_addr),
        .iresp_valid  (iresp_valid),
        .iresp_data   (iresp_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_we    (commit_we),
        .commit_rd    (commit_rd),
        .commit_wdata (commit_wdata)
    );

    always #5 clk = ~clk;

    // Small register window keeps dependencies frequent
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $urandom;
        return {2'b00, r[2:0]};
    endfunction

    function automatic inst_t random_inst();
        logic [31:0] r;
        logic [12:0] bo;
        logic [20:0] jo;
        logic [2:0]  f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        int          kind;
        r    = $urandom;
        kind = $urandom_range(15, 0);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        // Nonzero word offsets keep targets aligned
        bo   = 13'($urandom_range(8, 1)) << 2;
        if (r[0])
            bo = -bo;
        jo   = 21'($urandom_range(8, 1)) << 2;
        if (r[1])
            jo = -jo;
        case (r[3:2])
            2'd0:    f3 = F3_ADD;
            2'd1:    f3 = F3_XOR;
            2'd2:    f3 = F3_OR;
            default: f3 = F3_AND;
        endcase
        case (kind)
            0:       return {F7_BASE, rs2, rs1, F3_ADD, rd, OPC_OP};
            1:       return {F7_ALT, rs2, rs1, F3_ADD, rd, OPC_OP};
            2:       return {F7_BASE, rs2, rs1, F3_AND, rd, OPC_OP};
            3:       return {F7_BASE, rs2, rs1, F3_OR, rd, OPC_OP};
            4:       return {F7_BASE, rs2, rs1, F3_XOR, rd, OPC_OP};
            5:       return {F7_BASE, rs2, rs1, F3_SLT, rd, OPC_OP};
            6:       return {F7_BASE, rs2, rs1, F3_SLL, rd, OPC_OP};
            7:       return {F7_BASE, rs2, rs1, F3_SRL, rd, OPC_OP};
            8, 9, 10: return {r[31:20], rs1, f3, rd, OPC_OP_IMM};
            11:      return {r[31:12], rd, OPC_LUI};
            12, 13:  return {bo[12], bo[10:5], rs2, rs1, r[4] ? F3_BNE : F3_BEQ,
                             bo[4:1], bo[11], OPC_BRANCH};
            14:      return {jo[20], jo[10:1], jo[11], jo[19:12], rd, OPC_JAL};
            // Unsupported opcode retires as a no-op
            default: return {r[31:7], 7'b0001011};
        endcase
    endfunction

    // ISA model stepping one instruction per call
    function automatic commit_rec_t step_reference();
        commit_rec_t e;
        inst_t       i;
        word_t       a;
        word_t       b;
        word_t       imm_i;
        word_t       res;
        addr_t       next_pc;
        i       = prog_mem[ref_pc[7:2]];
        a       = ref_regs[i[19:15]];
        b       = ref_regs[i[24:20]];
        imm_i   = {{20{i[31]}}, i[31:20]};
        res     = '0;
        next_pc = ref_pc + 32'd4;
        e.we    = 1'b0;
        case (i[6:0])
            OPC_OP: begin
                e.we = 1'b1;
                case ({i[31:25], i[14:12]})
                    {F7_BASE, F3_ADD}: res = a + b;
                    {F7_ALT, F3_ADD}:  res = a - b;
                    {F7_BASE, F3_AND}: res = a & b;
                    {F7_BASE, F3_OR}:  res = a | b;
                    {F7_BASE, F3_XOR}: res = a ^ b;
                    {F7_BASE, F3_SLT}: res = {31'b0, $signed(a) < $signed(b)};
                    {F7_BASE, F3_SLL}: res = a << b[4:0];
                    {F7_BASE, F3_SRL}: res = a >> b[4:0];
                    default:           e.we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                e.we = 1'b1;
                case (i[14:12])
                    F3_ADD:  res = a + imm_i;
                    F3_AND:  res = a & imm_i;
                    F3_OR:   res = a | imm_i;
                    F3_XOR:  res = a ^ imm_i;
                    default: e.we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                e.we = 1'b1;
                res  = {i[31:12], 12'h000};
            end
            OPC_BRANCH: begin
                if ((i[14:12] == F3_BEQ && a == b) || (i[14:12] == F3_BNE && a != b))
                    next_pc = ref_pc + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            end
            OPC_JAL: begin
                e.we    = 1'b1;
                res     = ref_pc + 32'd4;
                next_pc = ref_pc + {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            end
            default: e.we = 1'b0;
        endcase
        if (i[11:7] == 5'd0)
            e.we = 1'b0;
        if (e.we)
            ref_regs[i[11:7]] = res;
        e.pc    = ref_pc;
        e.inst  = i;
        e.rd    = i[11:7];
        e.wdata = res;
        ref_pc  = next_pc;
        return e;
    endfunction

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            verdict_shown = 1'b1;
            $display("STATUS: FAIL");
            $fatal(1, "commit trace differs from the reference model");
        end
    endtask

    // Registered commit outputs sampled mid-cycle
    task automatic wait_for_commit();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Error at %0t ns: no instruction retired within the timeout", $time);
                verdict_shown = 1'b1;
                $display("STATUS: FAIL");
                $fatal(1, "commit timeout");
            end
        end while (commit_valid !== 1'b1);
    endtask

    // Instruction memory answering each request in 1 to 4 cycles
    initial begin : bus_model
        int   delay;
        logic busy;
        iresp_valid = 1'b0;
        iresp_data  = '0;
        busy        = 1'b0;
        delay       = 0;
        forever begin
            @(posedge clk);
            #1;
            if (iresp_valid) begin
                iresp_valid = 1'b0;
                busy        = 1'b0;
            end
            if (rst) begin
                busy = 1'b0;
            end else if (ireq_valid) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom_range(3, 0);
                end else begin
                    delay--;
                end
                if (delay == 0) begin
                    iresp_valid = 1'b1;
                    iresp_data  = prog_mem[ireq_addr[7:2]];
                end
            end
        end
    end

    initial begin : main_seq
        commit_rec_t e;
        clk           = 1'b0;
        rst           = 1'b1;
        verdict_shown = 1'b0;
        void'($urandom(32'h71aaefa3));
        for (int n = 0; n < MEM_WORDS; n++) begin
            prog_mem[n] = random_inst();
        end
        for (int n = 0; n < `CORE_NREGS; n++) begin
            ref_regs[n] = '0;
        end
        ref_pc = `CORE_RESET_PC;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < NUM_COMMITS; n++) begin
            wait_for_commit();
            e = step_reference();
            compare_value("commit_pc", e.pc, commit_pc);
            compare_value("commit_inst", e.inst, commit_inst);
            compare_value("commit_we", 32'(e.we), 32'(commit_we));
            if (e.we) begin
                compare_value("commit_rd", 32'(e.rd), 32'(commit_rd));
                compare_value("commit_wdata", e.wdata, commit_wdata);
            end
        end
        verdict_shown = 1'b1;
        $display("STATUS: PASS");
        $finish;
    end

    // Run stopped early by a failed assertion
    final begin
        if (!verdict_shown) begin
            $display("STATUS: FAIL");
        end
    end

endmodule

// File: sources.f
+incdir+logic
logic/core_pkg.sv
logic/core_top.sv
logic/fetch_stage.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/commit_stage.sv
verif/core_assert.sv
verif/core_tb.sv

// File: Makefile
SIM := obj_dir/Vcore_tb

SRCS := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module core_tb \
		-f sources.f -Mdir obj_dir

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
